// ==== design/display_defines.svh ====
// timing and geometry constants for the 640x480 60 Hz flag display
// include wherever a coordinate width, phase length or flag bound is needed

`ifndef DISPLAY_DEFINES_SVH
`define DISPLAY_DEFINES_SVH

// screen coordinate width, covers 0..799 and 0..524
`define CORDW 10

// horizontal phases, in pixels
`define H_ACTIVE 640  // visible pixels
`define H_FRONT 16    // front porch
`define H_SYNC 96     // sync pulse
`define H_BACK 48     // back porch
`define H_TOTAL 800   // full line

// vertical phases, in lines
`define V_ACTIVE 480  // visible lines
`define V_FRONT 10    // front porch
`define V_SYNC 2      // sync pulse
`define V_BACK 33     // back porch
`define V_TOTAL 525   // full frame

// flag of Sweden, 16:10 area at the top of the screen
// rows from FLAG_BOTTOM down stay black
`define FLAG_BOTTOM 400

// cross bands, open intervals between LO and HI
`define CROSS_Y_LO 160  // horizontal bar top
`define CROSS_Y_HI 240  // horizontal bar bottom
`define CROSS_X_LO 200  // vertical bar left
`define CROSS_X_HI 280  // vertical bar right

`endif

// ==== design/display_if.sv ====
// scan position and sync levels shared by the timing and pixel blocks
// counter drives position, fsm drives levels, sinks only read

`timescale 1ns/1ps
`include "display_defines.svh"

interface display_if;
    logic [`CORDW-1:0] sx;  // horizontal position
    logic [`CORDW-1:0] sy;  // vertical position
    logic line_end;         // last pixel of a line
    logic frame_end;        // last pixel of a frame
    logic hsync;            // active low
    logic vsync;            // active low
    logic de;               // visible area

    modport counter_mp (
        output sx, sy, line_end, frame_end
    );

    modport fsm_mp (
        input  sx, sy, line_end, frame_end,
        output hsync, vsync, de
    );

    modport sink_mp (
        input sx, sy, line_end, frame_end, hsync, vsync, de
    );
endinterface

// ==== design/display_pkg.sv ====
// shared types for the display pipeline
// phase encodings for the sync machines and the 12-bit pixel colour

package display_pkg;

    // horizontal phase, in scan order
    typedef enum logic [1:0] {
        H_ACTIVE_S, // visible pixels
        H_FRONT_S,  // front porch
        H_SYNC_S,   // hsync low
        H_BACK_S    // back porch
    } h_phase_e;

    // vertical phase, in scan order
    typedef enum logic [1:0] {
        V_ACTIVE_S, // visible lines
        V_FRONT_S,  // front porch
        V_SYNC_S,   // vsync low
        V_BACK_S    // back porch
    } v_phase_e;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb444_t;

    // palette
    localparam rgb444_t BLACK  = '{red: 4'h0, green: 4'h0, blue: 4'h0};
    localparam rgb444_t YELLOW = '{red: 4'hF, green: 4'hC, blue: 4'h0};
    localparam rgb444_t BLUE   = '{red: 4'h0, green: 4'h6, blue: 4'hA};

endpackage

// ==== design/display_top.sv ====
// 640x480 flag test pattern, 12-bit colour on a DVI style port
// run clk_pix at the 25.2 MHz pixel rate, reset stands in for PLL lock

`timescale 1ns/1ps

module display_top import display_pkg::*; (
    input  logic       clk_pix,    // pixel clock
    input  logic       reset,      // sync, active high
    output logic       dvi_hsync,  // horizontal sync, active low
    output logic       dvi_vsync,  // vertical sync, active low
    output logic       dvi_de,     // data enable
    output logic [3:0] dvi_r,      // red
    output logic [3:0] dvi_g,      // green
    output logic [3:0] dvi_b       // blue
);

    display_if scan_bus ();  // position and sync levels

    rgb444_t paint;  // painter to output stage
    rgb444_t rgb_q;  // registered colour

    scan_counter scan_counter_inst (
        .clk_pix,
        .reset,
        .bus     (scan_bus.counter_mp)
    );

    sync_fsm sync_fsm_inst (
        .clk_pix,
        .reset,
        .bus     (scan_bus.fsm_mp)
    );

    flag_painter flag_painter_inst (
        .bus     (scan_bus.sink_mp),
        .paint
    );

    pixel_out_reg pixel_out_reg_inst (
        .clk_pix,
        .reset,
        .bus     (scan_bus.sink_mp),
        .paint,
        .hsync_q (dvi_hsync),
        .vsync_q (dvi_vsync),
        .de_q    (dvi_de),
        .rgb_q
    );

    // split colour onto the pins
    assign dvi_r = rgb_q.red;
    assign dvi_g = rgb_q.green;
    assign dvi_b = rgb_q.blue;

endmodule

// ==== design/flag_painter.sv ====
// test pattern, flag of Sweden on the top 400 rows
// purely combinational, colour follows the current scan position

`timescale 1ns/1ps
`include "display_defines.svh"

module flag_painter import display_pkg::*; (
    display_if.sink_mp bus,   // scan position
    output rgb444_t    paint  // colour for this position
);

    localparam logic [`CORDW-1:0] FLAG_BOTTOM = `CORDW'(`FLAG_BOTTOM);
    localparam logic [`CORDW-1:0] CROSS_Y_LO  = `CORDW'(`CROSS_Y_LO);
    localparam logic [`CORDW-1:0] CROSS_Y_HI  = `CORDW'(`CROSS_Y_HI);
    localparam logic [`CORDW-1:0] CROSS_X_LO  = `CORDW'(`CROSS_X_LO);
    localparam logic [`CORDW-1:0] CROSS_X_HI  = `CORDW'(`CROSS_X_HI);

    logic below_flag;  // outside the 16:10 area
    logic in_hbar;     // horizontal bar of the cross
    logic in_vbar;     // vertical bar of the cross

    assign below_flag = (bus.sy >= FLAG_BOTTOM);
    assign in_hbar    = (bus.sy > CROSS_Y_LO) && (bus.sy < CROSS_Y_HI);
    assign in_vbar    = (bus.sx > CROSS_X_LO) && (bus.sx < CROSS_X_HI);

    // priority matters, black rows override the vertical bar
    always_comb begin
        if (below_flag) begin
            paint = BLACK;
        end else if (in_hbar) begin
            paint = YELLOW;
        end else if (in_vbar) begin
            paint = YELLOW;
        end else begin
            paint = BLUE;   // field
        end
    end

endmodule

// ==== design/pixel_out_reg.sv ====
// pin register stage, one cycle of latency for sync, enable and colour
// colour is forced black outside the visible area

`timescale 1ns/1ps

module pixel_out_reg import display_pkg::*; (
    input  logic    clk_pix,      // pixel clock
    input  logic    reset,        // sync, active high
    display_if.sink_mp bus,       // sync levels
    input  rgb444_t paint,        // painter colour
    output logic    hsync_q,      // registered hsync
    output logic    vsync_q,      // registered vsync
    output logic    de_q,         // registered enable
    output rgb444_t rgb_q         // registered colour
);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_q <= 1'b1;      // syncs idle high
            vsync_q <= 1'b1;
            de_q    <= 1'b0;
            rgb_q   <= BLACK;
        end else begin
            hsync_q <= bus.hsync;
            vsync_q <= bus.vsync;
            de_q    <= bus.de;
            if (bus.de) begin
                rgb_q <= paint;
            end else begin
                rgb_q <= BLACK;   // blanking
            end
        end
    end

endmodule

// ==== design/scan_counter.sv ====
// screen position counter for the 800x525 raster
// wraps sx every line and sy every frame, flags the last pixel of each

`timescale 1ns/1ps
`include "display_defines.svh"

module scan_counter (
    input  logic clk_pix,             // pixel clock
    input  logic reset,               // sync, active high
    display_if.counter_mp bus         // position out
);

    localparam logic [`CORDW-1:0] SX_LAST = `CORDW'(`H_TOTAL - 1);  // 799
    localparam logic [`CORDW-1:0] SY_LAST = `CORDW'(`V_TOTAL - 1);  // 524

    logic [`CORDW-1:0] sx;  // current column
    logic [`CORDW-1:0] sy;  // current row
    logic line_end;
    logic frame_end;

    // end pulses decode the live position
    assign line_end  = (sx == SX_LAST);
    assign frame_end = line_end && (sy == SY_LAST);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;               // start at top left
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;               // new line
            if (frame_end) begin
                sy <= '0;           // new frame
            end else begin
                sy <= sy + 1'b1;    // next row
            end
        end else begin
            sx <= sx + 1'b1;        // next pixel
        end
    end

    // drive the shared bus
    assign bus.sx        = sx;
    assign bus.sy        = sy;
    assign bus.line_end  = line_end;
    assign bus.frame_end = frame_end;

endmodule

// ==== design/sync_fsm.sv ====
// horizontal and vertical phase machines for 640x480 timing
// state always matches the current sx/sy, syncs and de are decoded from it

`timescale 1ns/1ps
`include "display_defines.svh"

module sync_fsm import display_pkg::*; (
    input  logic clk_pix,         // pixel clock
    input  logic reset,           // sync, active high
    display_if.fsm_mp bus         // position in, sync levels out
);

    // last column of each horizontal phase, back porch ends on line_end
    localparam logic [`CORDW-1:0] H_ACT_LAST  = `CORDW'(`H_ACTIVE - 1);
    localparam logic [`CORDW-1:0] H_FP_LAST   = `CORDW'(`H_ACTIVE + `H_FRONT - 1);
    localparam logic [`CORDW-1:0] H_SYNC_LAST = `CORDW'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1);

    // last row of each vertical phase, back porch ends on frame_end
    localparam logic [`CORDW-1:0] V_ACT_LAST  = `CORDW'(`V_ACTIVE - 1);
    localparam logic [`CORDW-1:0] V_FP_LAST   = `CORDW'(`V_ACTIVE + `V_FRONT - 1);
    localparam logic [`CORDW-1:0] V_SYNC_LAST = `CORDW'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);

    h_phase_e h_state;
    h_phase_e h_next;
    v_phase_e v_state;
    v_phase_e v_next;

    // horizontal, steps on the edge leaving each phase's last column
    always_comb begin
        h_next = h_state;
        case (h_state)
            H_ACTIVE_S: begin
                if (bus.sx == H_ACT_LAST) h_next = H_FRONT_S;   // into front porch
            end
            H_FRONT_S: begin
                if (bus.sx == H_FP_LAST) h_next = H_SYNC_S;     // sync pulse starts
            end
            H_SYNC_S: begin
                if (bus.sx == H_SYNC_LAST) h_next = H_BACK_S;   // sync released
            end
            H_BACK_S: begin
                if (bus.line_end) h_next = H_ACTIVE_S;          // back to column 0
            end
            default: h_next = H_ACTIVE_S;
        endcase
    end

    // vertical, only moves at the end of a line
    always_comb begin
        v_next = v_state;
        if (bus.line_end) begin
            case (v_state)
                V_ACTIVE_S: begin
                    if (bus.sy == V_ACT_LAST) v_next = V_FRONT_S;
                end
                V_FRONT_S: begin
                    if (bus.sy == V_FP_LAST) v_next = V_SYNC_S;
                end
                V_SYNC_S: begin
                    if (bus.sy == V_SYNC_LAST) v_next = V_BACK_S;
                end
                V_BACK_S: begin
                    if (bus.frame_end) v_next = V_ACTIVE_S;     // frame wrap
                end
                default: v_next = V_ACTIVE_S;
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            h_state <= H_ACTIVE_S;  // (0,0) is visible
            v_state <= V_ACTIVE_S;
        end else begin
            h_state <= h_next;
            v_state <= v_next;
        end
    end

    // level decodes, both syncs negative polarity
    assign bus.hsync = (h_state != H_SYNC_S);
    assign bus.vsync = (v_state != V_SYNC_S);
    assign bus.de    = (h_state == H_ACTIVE_S) && (v_state == V_ACTIVE_S);

endmodule

// ==== tb.f ====
+incdir+design
design/display_pkg.sv
design/display_if.sv
design/scan_counter.sv
design/sync_fsm.sv
design/flag_painter.sv
design/pixel_out_reg.sv
design/display_top.sv
verif/display_top_assert.sv
verif/display_top_tb.sv

// ==== verif/display_top_assert.sv ====
// concurrent checks on the registered display outputs
// bound onto display_top, sees only the top level pins, failures are counted

`timescale 1ns/1ps

module display_top_assert (
    input logic       clk_pix,    // pixel clock
    input logic       reset,      // sync, active high
    input logic       dvi_hsync,
    input logic       dvi_vsync,
    input logic       dvi_de,
    input logic [3:0] dvi_r,
    input logic [3:0] dvi_g,
    input logic [3:0] dvi_b
);

    int fail_count = 0;  // failed assertions so far

    // no visible pixel inside either sync pulse
    de_outside_sync: assert property (@(posedge clk_pix) disable iff (reset)
        dvi_de |-> (dvi_hsync && dvi_vsync))
        else begin
            $error("dvi_de high while a sync is low");
            fail_count++;
        end

    // blanking carries black only
    black_in_blanking: assert property (@(posedge clk_pix) disable iff (reset)
        !dvi_de |-> ({dvi_r, dvi_g, dvi_b} == 12'h000))
        else begin
            $error("colour not black while dvi_de is low");
            fail_count++;
        end

    // vsync moves at a line start, 48 pixels after hsync releases
    vsync_at_line_start: assert property (@(posedge clk_pix) disable iff (reset)
        (dvi_vsync != $past(dvi_vsync)) |-> ($past(dvi_hsync, 48) && !$past(dvi_hsync, 49)))
        else begin
            $error("dvi_vsync changed away from a line start");
            fail_count++;
        end

    // reset loads idle levels one edge later
    idle_after_reset: assert property (@(posedge clk_pix)
        reset |=> (dvi_hsync && dvi_vsync && !dvi_de && ({dvi_r, dvi_g, dvi_b} == 12'h000)))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

endmodule

bind display_top display_top_assert i_display_top_assert (.*);

// ==== verif/display_top_tb.sv ====
// testbench for the flag display, compares every output cycle with a model
// two full frames, then a reset at a random point in the third frame

`timescale 1ns/1ps
`include "display_defines.svh"

module display_top_tb;

    localparam int CLK_PERIOD   = 40;                     // ns
    localparam int RESET_CYCLES = 8;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;    // 420000
    localparam int WATCHDOG_NS  = (3 * FRAME_CYCLES + 2 * RESET_CYCLES) * CLK_PERIOD;

    logic       clk_pix;
    logic       reset;
    logic       dvi_hsync;
    logic       dvi_vsync;
    logic       dvi_de;
    logic [3:0] dvi_r;
    logic [3:0] dvi_g;
    logic [3:0] dvi_b;

    logic [31:0] seed;           // random state
    int          mid_cycle;      // cycles into frame three before the reset
    string       test_name;      // current test step
    string       label;          // test step plus position
    logic [14:0] exp_val;        // {hsync, vsync, de, rgb}
    logic        in_frame;       // model tracks a position
    int          msx = 0;        // model position for the next edge
    int          msy = 0;
    int          cur_sx = 0;     // position shown at the outputs now
    int          cur_sy = 0;
    int          de_cnt = 0;     // per line
    int          hs_cnt = 0;
    int          vs_lines = 0;   // per frame
    int          frames_done = 0;

    display_top i_display_top (
        .clk_pix,
        .reset,
        .dvi_hsync,
        .dvi_vsync,
        .dvi_de,
        .dvi_r,
        .dvi_g,
        .dvi_b
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    // expected pins for a scan position, straight from the 640x480 timing
    function automatic logic [14:0] ref_pixel(input int px, input int py);
        logic        hs;
        logic        vs;
        logic        de;
        logic [11:0] rgb;
        hs = !((px >= `H_ACTIVE + `H_FRONT) && (px < `H_ACTIVE + `H_FRONT + `H_SYNC));
        vs = !((py >= `V_ACTIVE + `V_FRONT) && (py < `V_ACTIVE + `V_FRONT + `V_SYNC));
        de = (px < `H_ACTIVE) && (py < `V_ACTIVE);
        if (!de) rgb = 12'h000;                                          // blanking
        else if (py >= `FLAG_BOTTOM) rgb = 12'h000;                      // below flag
        else if ((py > `CROSS_Y_LO) && (py < `CROSS_Y_HI)) rgb = 12'hFC0;  // horizontal bar
        else if ((px > `CROSS_X_LO) && (px < `CROSS_X_HI)) rgb = 12'hFC0;  // vertical bar
        else rgb = 12'h06A;                                              // blue field
        return {hs, vs, de, rgb};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] expected %0h actual %0h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    // model steps on each edge, outputs compared at the falling edge
    always begin
        @(posedge clk_pix);
        if (reset) begin
            in_frame = 1'b0;
            exp_val  = {1'b1, 1'b1, 1'b0, 12'h000};  // idle pins
            msx      = 0;
            msy      = 0;
        end else begin
            in_frame = 1'b1;
            cur_sx   = msx;
            cur_sy   = msy;
            exp_val  = ref_pixel(msx, msy);
            msx      = (msx == `H_TOTAL - 1) ? 0 : msx + 1;
            if (msx == 0) msy = (msy == `V_TOTAL - 1) ? 0 : msy + 1;
        end
        @(negedge clk_pix);
        if (in_frame) label = $sformatf("%s (%0d,%0d)", test_name, cur_sx, cur_sy);
        else label = {test_name, " idle"};
        check_value({label, " hsync"}, exp_val[14], dvi_hsync);
        check_value({label, " vsync"}, exp_val[13], dvi_vsync);
        check_value({label, " de"}, exp_val[12], dvi_de);
        check_value({label, " colour"}, exp_val[11:0], {dvi_r, dvi_g, dvi_b});
        check_value({label, " assertion failures"}, 0,
                    i_display_top.i_display_top_assert.fail_count);
        if (in_frame) begin
            if (dvi_de) de_cnt++;
            if (!dvi_hsync) hs_cnt++;
            if (cur_sx == `H_TOTAL - 1) begin  // line summary
                check_value({label, " de width"}, (cur_sy < `V_ACTIVE) ? `H_ACTIVE : 0, de_cnt);
                check_value({label, " hsync width"}, `H_SYNC, hs_cnt);
                if (!dvi_vsync) vs_lines++;
                de_cnt = 0;
                hs_cnt = 0;
                if (cur_sy == `V_TOTAL - 1) begin  // frame summary
                    check_value({label, " vsync lines"}, `V_SYNC, vs_lines);
                    vs_lines = 0;
                    frames_done++;
                end
            end
        end else begin
            de_cnt   = 0;
            hs_cnt   = 0;
            vs_lines = 0;
        end
    end

    initial begin
        seed      = 32'h226b;
        reset     = 1'b1;        // held from time zero
        test_name = "power-on reset";
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 reset = 1'b0;
        test_name = "frames 1-2";
        repeat (2 * FRAME_CYCLES) @(posedge clk_pix);
        @(negedge clk_pix);
        #1;                      // frame summary of the last edge done
        check_value("frame count", 2, frames_done);
        mid_cycle = 1000 + ($unsigned($random(seed)) % 300000);  // rows 1..376
        test_name = "frame 3";
        repeat (mid_cycle) @(posedge clk_pix);
        #1 reset = 1'b1;
        test_name = "mid-frame reset";
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 reset = 1'b0;
        test_name = "restart";
        repeat (4 * `H_TOTAL) @(posedge clk_pix);
        @(negedge clk_pix);
        #1;                      // last compare done
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run timed out before all frames were checked");
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

endmodule
